// ==== matmul_pkg.sv ====
package matmul_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Elements per memory word, also the edge of the cell grid
  localparam int LANES = 4;

  // One matrix element
  localparam int DATA_WIDTH = 16;

  // Bank address
  localparam int ADDR_WIDTH = 7;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // One memory word, lane 0 in the low bits
  typedef logic [LANES*DATA_WIDTH-1:0] vec_t;

  // Engine sequence
  typedef enum logic [2:0] {
    idle,
    feed,
    drain,
    write_back,
    finish
  } engine_state_t;

  ////////////////////////////////////////
  // Engine cycle counts
  ////////////////////////////////////////

  // Operand words read from each of A and B
  localparam int FEED_CYCLES = LANES;

  // Wait after the last feed until the skewed operands have left the grid
  localparam int DRAIN_CYCLES = 2 * LANES;

endpackage

// ==== bank_port_if.sv ====
`timescale 1ns/1ps

interface bank_port_if;
  import matmul_pkg::*;

  // Word address into the bank
  addr_t addr;

  // Write path, used only on the result bank
  vec_t  wdata;
  logic  we;

  // Registered read data, two cycles after addr
  vec_t  rdata;

  modport engine (
    output addr,
    output wdata,
    output we,
    input  rdata
  );

  modport bank (
    input  addr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

// ==== matrix_bank.sv ====
`timescale 1ns/1ps

module matrix_bank #(
  parameter int MEM_DEPTH = 128
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              host_select,
  input  matmul_pkg::addr_t host_addr,
  input  matmul_pkg::vec_t  host_wdata,
  input  logic              host_we,
  bank_port_if.bank         eng
);
  import matmul_pkg::*;

  vec_t  mem [MEM_DEPTH];
  addr_t addr_q;
  vec_t  wdata_q;
  logic  we_q;

  ////////////////////////////////////////
  // Port select stage
  ////////////////////////////////////////

  // Host or engine owns the bank for this access
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q <= '0;
      we_q   <= 1'b0;
    end else begin
      addr_q <= host_select ? host_addr : eng.addr;
      we_q   <= host_select ? host_we : eng.we;
    end
  end

  always_ff @(posedge clk) begin
    wdata_q <= host_select ? host_wdata : eng.wdata;
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Single port, a write cycle gives no read data
  always_ff @(posedge clk) begin
    if (we_q) begin
      mem[addr_q] <= wdata_q;
    end else begin
      eng.rdata <= mem[addr_q];
    end
  end

endmodule

// ==== mac_cell.sv ====
`timescale 1ns/1ps

module mac_cell (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::data_t a_in,
  input  matmul_pkg::data_t b_in,
  output matmul_pkg::data_t a_out,
  output matmul_pkg::data_t b_out,
  output matmul_pkg::data_t acc
);

  // Accumulator, the sum keeps only its low 16 bits
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (clear) begin
      acc <= '0;
    end else begin
      acc <= acc + a_in * b_in;
    end
  end

  // A moves right, B moves down, one cell per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      a_out <= '0;
      b_out <= '0;
    end else begin
      a_out <= a_in;
      b_out <= b_in;
    end
  end

endmodule

// ==== systolic_array.sv ====
`timescale 1ns/1ps

module systolic_array (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  matmul_pkg::vec_t a_col,
  input  matmul_pkg::vec_t b_row,
  output matmul_pkg::vec_t result [matmul_pkg::LANES]
);
  import matmul_pkg::*;

  // a_h[i][j] enters cell (i, j) from the left, b_v[i][j] from above
  data_t a_h [LANES][LANES+1];
  data_t b_v [LANES+1][LANES];

  ////////////////////////////////////////
  // Input skew
  ////////////////////////////////////////

  // Lane i waits i cycles so that matching A and B elements meet
  for (genvar i = 0; i < LANES; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign a_h[0][0] = a_col[DATA_WIDTH-1:0];
      assign b_v[0][0] = b_row[DATA_WIDTH-1:0];
    end else begin : g_delay
      data_t a_pipe [i];
      data_t b_pipe [i];

      always_ff @(posedge clk) begin
        if (reset) begin
          a_pipe <= '{default: '0};
          b_pipe <= '{default: '0};
        end else begin
          a_pipe[0] <= a_col[i*DATA_WIDTH +: DATA_WIDTH];
          b_pipe[0] <= b_row[i*DATA_WIDTH +: DATA_WIDTH];
          for (int d = 1; d < i; d++) begin
            a_pipe[d] <= a_pipe[d-1];
            b_pipe[d] <= b_pipe[d-1];
          end
        end
      end

      assign a_h[i][0] = a_pipe[i-1];
      assign b_v[0][i] = b_pipe[i-1];
    end
  end

  ////////////////////////////////////////
  // Cell grid
  ////////////////////////////////////////

  // Cell (i, j) accumulates C[i][j], straight into its result lane
  for (genvar i = 0; i < LANES; i++) begin : g_row
    for (genvar j = 0; j < LANES; j++) begin : g_col
      mac_cell u_cell (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .a_in  (a_h[i][j]),
        .b_in  (b_v[i][j]),
        .a_out (a_h[i][j+1]),
        .b_out (b_v[i+1][j]),
        .acc   (result[i][j*DATA_WIDTH +: DATA_WIDTH])
      );
    end
  end

endmodule

// ==== matmul_engine.sv ====
`timescale 1ns/1ps

module matmul_engine (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  output logic        done,
  bank_port_if.engine port_a,
  bank_port_if.engine port_b,
  bank_port_if.engine port_c
);
  import matmul_pkg::*;

  // Counter wide enough for the longest phase
  localparam int STEP_WIDTH = $clog2(DRAIN_CYCLES + 1);
  localparam int ROW_SEL_WIDTH = $clog2(LANES);

  engine_state_t         state;
  logic [STEP_WIDTH-1:0] step;
  logic                  clear;
  logic                  feed_d1;
  logic                  feed_d2;
  vec_t                  a_col;
  vec_t                  b_row;
  vec_t                  result [LANES];

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      step  <= '0;
      done  <= 1'b1;
      clear <= 1'b0;
    end else begin
      clear <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state <= feed;
            step  <= '0;
            done  <= 1'b0;
            clear <= 1'b1;
          end
        end
        feed: begin
          if (step == STEP_WIDTH'(FEED_CYCLES - 1)) begin
            step  <= '0;
            state <= drain;
          end else begin
            step <= step + 1'b1;
          end
        end
        drain: begin
          if (step == STEP_WIDTH'(DRAIN_CYCLES - 1)) begin
            step  <= '0;
            state <= write_back;
          end else begin
            step <= step + 1'b1;
          end
        end
        write_back: begin
          if (step == STEP_WIDTH'(LANES - 1)) begin
            step  <= '0;
            state <= finish;
          end else begin
            step <= step + 1'b1;
          end
        end
        finish: begin
          done  <= 1'b1;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Bank read latency is two cycles, the flag follows the data
  always_ff @(posedge clk) begin
    if (reset) begin
      feed_d1 <= 1'b0;
      feed_d2 <= 1'b0;
    end else begin
      feed_d1 <= (state == feed);
      feed_d2 <= feed_d1;
    end
  end

  ////////////////////////////////////////
  // Bank ports and array
  ////////////////////////////////////////

  // Operand banks are read only
  assign port_a.addr  = addr_t'(step);
  assign port_a.wdata = '0;
  assign port_a.we    = 1'b0;
  assign port_b.addr  = addr_t'(step);
  assign port_b.wdata = '0;
  assign port_b.we    = 1'b0;

  // Zeros outside the feed window keep the accumulators still
  assign a_col = feed_d2 ? port_a.rdata : '0;
  assign b_row = feed_d2 ? port_b.rdata : '0;

  systolic_array u_array (
    .clk    (clk),
    .reset  (reset),
    .clear  (clear),
    .a_col  (a_col),
    .b_row  (b_row),
    .result (result)
  );

  // One result row per write_back cycle
  assign port_c.addr  = addr_t'(step);
  assign port_c.wdata = result[step[ROW_SEL_WIDTH-1:0]];
  assign port_c.we    = (state == write_back);

endmodule

// ==== matmul_top.sv ====
`timescale 1ns/1ps

module matmul_top #(
  parameter int MEM_DEPTH = 128
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable_writing_to_mem,
  input  logic              enable_reading_from_mem,
  input  matmul_pkg::vec_t  data_pi,
  input  matmul_pkg::addr_t addr_pi,
  input  logic              we_a,
  input  logic              we_b,
  input  logic              start_mat_mul,
  output matmul_pkg::vec_t  data_from_out_mat,
  output logic              done_mat_mul
);
  import matmul_pkg::*;

  addr_t addr_q;
  vec_t  data_q;
  logic  we_a_q;
  logic  we_b_q;
  logic  wr_en_q;
  logic  rd_en_q;
  logic  rd_d1;
  logic  rd_d2;

  bank_port_if port_a ();
  bank_port_if port_b ();
  bank_port_if port_c ();

  ////////////////////////////////////////
  // Host port registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      we_a_q  <= 1'b0;
      we_b_q  <= 1'b0;
      wr_en_q <= 1'b0;
      rd_en_q <= 1'b0;
      addr_q  <= '0;
    end else begin
      we_a_q  <= we_a;
      we_b_q  <= we_b;
      wr_en_q <= enable_writing_to_mem;
      rd_en_q <= enable_reading_from_mem;
      addr_q  <= addr_pi;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= data_pi;
  end

  ////////////////////////////////////////
  // Banks and engine
  ////////////////////////////////////////

  matrix_bank #(.MEM_DEPTH(MEM_DEPTH)) bank_a (
    .clk         (clk),
    .reset       (reset),
    .host_select (wr_en_q),
    .host_addr   (addr_q),
    .host_wdata  (data_q),
    .host_we     (we_a_q),
    .eng         (port_a.bank)
  );

  matrix_bank #(.MEM_DEPTH(MEM_DEPTH)) bank_b (
    .clk         (clk),
    .reset       (reset),
    .host_select (wr_en_q),
    .host_addr   (addr_q),
    .host_wdata  (data_q),
    .host_we     (we_b_q),
    .eng         (port_b.bank)
  );

  // Host only reads the result bank
  matrix_bank #(.MEM_DEPTH(MEM_DEPTH)) bank_c (
    .clk         (clk),
    .reset       (reset),
    .host_select (rd_en_q),
    .host_addr   (addr_q),
    .host_wdata  (data_q),
    .host_we     (1'b0),
    .eng         (port_c.bank)
  );

  matmul_engine u_engine (
    .clk    (clk),
    .reset  (reset),
    .start  (start_mat_mul),
    .done   (done_mat_mul),
    .port_a (port_a.engine),
    .port_b (port_b.engine),
    .port_c (port_c.engine)
  );

  ////////////////////////////////////////
  // Result read path
  ////////////////////////////////////////

  // Read enable tracks the bank pipeline, output holds between reads
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_d1             <= 1'b0;
      rd_d2             <= 1'b0;
      data_from_out_mat <= '0;
    end else begin
      rd_d1 <= rd_en_q;
      rd_d2 <= rd_d1;
      if (rd_d2) begin
        data_from_out_mat <= port_c.rdata;
      end
    end
  end

endmodule

// ==== matmul_assertions.sv ====
`timescale 1ns/1ps

module matmul_assertions (
  input logic             clk,
  input logic             reset,
  input logic             start_mat_mul,
  input logic             done_mat_mul,
  input logic             enable_reading_from_mem,
  input matmul_pkg::vec_t data_from_out_mat
);

  // Count of failed assertions
  int failures = 0;

  // Start taken in idle drops done on the next edge
  a_done_falls: assert property (
    @(posedge clk) disable iff (reset)
      (start_mat_mul && done_mat_mul) |=> !done_mat_mul
  ) else begin
    $error("done_mat_mul did not fall after start_mat_mul");
    failures++;
  end

  // Idle engine stays ready until told to start
  a_done_holds: assert property (
    @(posedge clk) disable iff (reset)
      (done_mat_mul && !start_mat_mul) |=> done_mat_mul
  ) else begin
    $error("done_mat_mul dropped without start_mat_mul");
    failures++;
  end

  // Read path is full after three cycles of read enable
  a_read_known: assert property (
    @(posedge clk) disable iff (reset)
      enable_reading_from_mem [*3] |-> !$isunknown(data_from_out_mat)
  ) else begin
    $error("data_from_out_mat unknown during a held read");
    failures++;
  end

endmodule

bind matmul_top matmul_assertions u_assertions (
  .clk                     (clk),
  .reset                   (reset),
  .start_mat_mul           (start_mat_mul),
  .done_mat_mul            (done_mat_mul),
  .enable_reading_from_mem (enable_reading_from_mem),
  .data_from_out_mat       (data_from_out_mat)
);

// ==== tb_matmul.sv ====
`timescale 1ns/1ps

module tb_matmul;
  import matmul_pkg::*;

  localparam int MEM_DEPTH = 128;
  localparam int DRIVE_DELAY = 10;
  // Each test needs well under 200 cycles of writes, multiplies and reads
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int DONE_WAIT_CYCLES = 100;

  logic  clk;
  logic  reset;
  logic  enable_writing_to_mem;
  logic  enable_reading_from_mem;
  vec_t  data_pi;
  addr_t addr_pi;
  logic  we_a;
  logic  we_b;
  logic  start_mat_mul;
  vec_t  data_from_out_mat;
  logic  done_mat_mul;

  // Host view of the operands by [row][col]
  data_t mat_a [LANES][LANES];
  data_t mat_b [LANES][LANES];
  int    cycle_count = 0;

  matmul_top #(.MEM_DEPTH(MEM_DEPTH)) matmul_top_i (
    .clk                     (clk),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .start_mat_mul           (start_mat_mul),
    .data_from_out_mat       (data_from_out_mat),
    .done_mat_mul            (done_mat_mul)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic check_value(input string test_name, input vec_t expected, input vec_t actual);
    if (actual !== expected) begin
      $display("Error in %s: expected %h, actual %h", test_name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // C[i][j] is the full sum over k cut to its low bits
  function automatic vec_t expected_row(input int i);
    vec_t        row;
    logic [63:0] sum;
    row = '0;
    for (int j = 0; j < LANES; j++) begin
      sum = '0;
      for (int k = 0; k < LANES; k++) begin
        sum = sum + 64'(mat_a[i][k]) * 64'(mat_b[k][j]);
      end
      row[j*DATA_WIDTH +: DATA_WIDTH] = sum[DATA_WIDTH-1:0];
    end
    return row;
  endfunction

  task automatic randomize_matrix(input bit to_b, input int lo, input int hi);
    for (int r = 0; r < LANES; r++) begin
      for (int c = 0; c < LANES; c++) begin
        if (to_b) begin
          mat_b[r][c] = data_t'($urandom_range(hi, lo));
        end else begin
          mat_a[r][c] = data_t'($urandom_range(hi, lo));
        end
      end
    end
  endtask

  // A goes in by column and B by row
  task automatic write_matrix(input bit to_b);
    vec_t word;
    enable_writing_to_mem = 1'b1;
    we_a = !to_b;
    we_b = to_b;
    for (int k = 0; k < LANES; k++) begin
      for (int l = 0; l < LANES; l++) begin
        word[l*DATA_WIDTH +: DATA_WIDTH] = to_b ? mat_b[k][l] : mat_a[l][k];
      end
      addr_pi = addr_t'(k);
      data_pi = word;
      next_cycle();
    end
    enable_writing_to_mem = 1'b0;
    we_a = 1'b0;
    we_b = 1'b0;
    data_pi = '0;
    addr_pi = '0;
    // Let the last write leave the host pipeline
    next_cycle();
    next_cycle();
  endtask

  task automatic run_multiply(input string test_name);
    int waited;
    waited = 0;
    check_value(test_name, vec_t'(1'b1), vec_t'(done_mat_mul));
    start_mat_mul = 1'b1;
    next_cycle();
    start_mat_mul = 1'b0;
    check_value(test_name, vec_t'(1'b0), vec_t'(done_mat_mul));
    while (done_mat_mul !== 1'b1) begin
      if (waited >= DONE_WAIT_CYCLES) begin
        $display("Error in %s: done_mat_mul never came back after start", test_name);
        $display("Some tests failed");
        $fatal(1, "Engine did not finish");
      end else begin
        next_cycle();
        waited++;
      end
    end
  endtask

  // Address taken at the first edge, row shown three edges later
  task automatic read_row(input int row, output vec_t value);
    enable_reading_from_mem = 1'b1;
    addr_pi = addr_t'(row);
    repeat (4) @(posedge clk);
    #(DRIVE_DELAY);
    value = data_from_out_mat;
  endtask

  task automatic end_read();
    enable_reading_from_mem = 1'b0;
    addr_pi = '0;
    next_cycle();
    next_cycle();
  endtask

  task automatic read_result(input string test_name);
    vec_t value;
    for (int i = 0; i < LANES; i++) begin
      read_row(i, value);
      check_value(test_name, expected_row(i), value);
    end
    end_read();
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset();
    check_value("test_reset", vec_t'(1'b1), vec_t'(done_mat_mul));
    check_value("test_reset", '0, data_from_out_mat);
  endtask

  task automatic test_identity();
    vec_t value;
    vec_t b_row;
    for (int r = 0; r < LANES; r++) begin
      for (int c = 0; c < LANES; c++) begin
        mat_a[r][c] = (r == c) ? data_t'(1) : data_t'(0);
      end
    end
    randomize_matrix(1'b1, 0, 16'hffff);
    write_matrix(1'b0);
    write_matrix(1'b1);
    run_multiply("test_identity");
    for (int i = 0; i < LANES; i++) begin
      for (int j = 0; j < LANES; j++) begin
        b_row[j*DATA_WIDTH +: DATA_WIDTH] = mat_b[i][j];
      end
      read_row(i, value);
      check_value("test_identity", b_row, value);
    end
    end_read();
  endtask

  task automatic test_random_small();
    randomize_matrix(1'b0, 0, 63);
    randomize_matrix(1'b1, 0, 63);
    write_matrix(1'b0);
    write_matrix(1'b1);
    run_multiply("test_random_small");
    read_result("test_random_small");
  endtask

  // Every product overflows, so only the low bits can match
  task automatic test_wrap();
    randomize_matrix(1'b0, 16'hff00, 16'hffff);
    randomize_matrix(1'b1, 16'hff00, 16'hffff);
    write_matrix(1'b0);
    write_matrix(1'b1);
    run_multiply("test_wrap");
    read_result("test_wrap");
  endtask

  task automatic test_back_to_back();
    randomize_matrix(1'b0, 16'h8000, 16'hffff);
    randomize_matrix(1'b1, 16'h8000, 16'hffff);
    write_matrix(1'b0);
    write_matrix(1'b1);
    run_multiply("test_back_to_back_first");
    read_result("test_back_to_back_first");
    // With A at zero any sum left over in the grid would show
    randomize_matrix(1'b0, 0, 0);
    randomize_matrix(1'b1, 0, 16'hffff);
    write_matrix(1'b0);
    write_matrix(1'b1);
    run_multiply("test_back_to_back_second");
    read_result("test_back_to_back_second");
  endtask

  task automatic test_rewrite_b();
    randomize_matrix(1'b0, 0, 255);
    randomize_matrix(1'b1, 0, 255);
    write_matrix(1'b0);
    write_matrix(1'b1);
    run_multiply("test_rewrite_b_first");
    read_result("test_rewrite_b_first");
    randomize_matrix(1'b1, 0, 255);
    write_matrix(1'b1);
    run_multiply("test_rewrite_b_second");
    read_result("test_rewrite_b_second");
  endtask

  initial begin
    void'($urandom(32'h7774_73f6));
    reset = 1'b1;
    enable_writing_to_mem = 1'b0;
    enable_reading_from_mem = 1'b0;
    data_pi = '0;
    addr_pi = '0;
    we_a = 1'b0;
    we_b = 1'b0;
    start_mat_mul = 1'b0;
    repeat (3) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;

    test_reset();
    test_identity();
    test_random_small();
    test_wrap();
    test_back_to_back();
    test_rewrite_b();

    if (matmul_top_i.u_assertions.failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
matmul_pkg.sv
bank_port_if.sv
matrix_bank.sv
mac_cell.sv
systolic_array.sv
matmul_engine.sv
matmul_top.sv
matmul_assertions.sv
tb_matmul.sv
